// ==== logic/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path width, RV32I only
`define RV_XLEN 32

// register index width and register count
`define RV_REG_AW 5
`define RV_NUM_REGS 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;      // data or address word
  typedef logic [`RV_REG_AW-1:0] reg_addr_t; // register index

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OP     = 7'b011_0011,
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    BRANCH = 7'b110_0011
  } opcode_e;

  // funct3 for OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000, // add/sub
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101, // srl/sra
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  // funct3 for BRANCH, 3'b010 and 3'b011 are unused
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_f3_e;

endpackage

`default_nettype wire

// ==== logic/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9
  } alu_op_e;

  // first alu operand
  typedef enum logic [1:0] {
    RS1  = 2'd0,
    PC   = 2'd1,
    ZERO = 2'd2
  } a_sel_e;

  typedef enum logic {
    RS2 = 1'b0,
    IMM = 1'b1
  } b_sel_e;

  // next pc source
  typedef enum logic [1:0] {
    SEQ    = 2'd0,
    BRANCH = 2'd1,
    JAL    = 2'd2,
    JALR   = 2'd3
  } pc_sel_e;

  typedef enum logic {
    ALU  = 1'b0,
    LINK = 1'b1  // pc + 4
  } wb_sel_e;

endpackage

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  rv_isa_pkg::word_t         inst,
  output rv_isa_pkg::reg_addr_t     rs1_addr,
  output rv_isa_pkg::reg_addr_t     rs2_addr,
  output rv_isa_pkg::reg_addr_t     rd_addr,
  output rv_isa_pkg::word_t         imm,
  output core_ctrl_pkg::alu_op_e    alu_op,
  output core_ctrl_pkg::a_sel_e     a_sel,
  output core_ctrl_pkg::b_sel_e     b_sel,
  output rv_isa_pkg::branch_f3_e    branch_cond,
  output core_ctrl_pkg::pc_sel_e    pc_sel,
  output core_ctrl_pkg::wb_sel_e    wb_sel,
  output logic                      rd_wen
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_e funct3;
  logic                alt;    // funct7[5], selects sub/sra
  rv_isa_pkg::word_t   imm_i;
  rv_isa_pkg::word_t   imm_sh;
  rv_isa_pkg::word_t   imm_b;
  rv_isa_pkg::word_t   imm_u;
  rv_isa_pkg::word_t   imm_j;

  // funct3 to alu operation, sub only allowed for register-register
  function automatic core_ctrl_pkg::alu_op_e alu_op_for(
    input rv_isa_pkg::funct3_e f3,
    input logic                f7_alt,
    input logic                sub_ok
  );
    core_ctrl_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::F3_ADD:  op = (f7_alt && sub_ok) ? core_ctrl_pkg::SUB : core_ctrl_pkg::ADD;
      rv_isa_pkg::F3_SLL:  op = core_ctrl_pkg::SLL;
      rv_isa_pkg::F3_SLT:  op = core_ctrl_pkg::SLT;
      rv_isa_pkg::F3_SLTU: op = core_ctrl_pkg::SLTU;
      rv_isa_pkg::F3_XOR:  op = core_ctrl_pkg::XOR;
      rv_isa_pkg::F3_SR:   op = f7_alt ? core_ctrl_pkg::SRA : core_ctrl_pkg::SRL;
      rv_isa_pkg::F3_OR:   op = core_ctrl_pkg::OR;
      default:             op = core_ctrl_pkg::AND;
    endcase
    return op;
  endfunction

  assign opcode   = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3   = rv_isa_pkg::funct3_e'(inst[14:12]);
  assign alt      = inst[30];
  assign rd_addr  = inst[11:7];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign branch_cond = rv_isa_pkg::branch_f3_e'(inst[14:12]);

  // sign-extended immediates
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_sh = {27'b0, inst[24:20]}; // shamt of slli/srli/srai
  assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'b0};
  assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults describe an instruction that writes nothing
    imm    = imm_i;
    alu_op = core_ctrl_pkg::ADD;
    a_sel  = core_ctrl_pkg::RS1;
    b_sel  = core_ctrl_pkg::RS2;
    pc_sel = core_ctrl_pkg::SEQ;
    wb_sel = core_ctrl_pkg::ALU;
    rd_wen = 1'b0;

    case (opcode)
      rv_isa_pkg::OP: begin
        alu_op = alu_op_for(funct3, alt, 1'b1);
        rd_wen = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SR) begin
          imm = imm_sh;
        end
        alu_op = alu_op_for(funct3, alt, 1'b0);
        b_sel  = core_ctrl_pkg::IMM;
        rd_wen = 1'b1;
      end
      rv_isa_pkg::LUI: begin
        imm    = imm_u;
        a_sel  = core_ctrl_pkg::ZERO;  // 0 + imm
        b_sel  = core_ctrl_pkg::IMM;
        rd_wen = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        imm    = imm_u;
        a_sel  = core_ctrl_pkg::PC;
        b_sel  = core_ctrl_pkg::IMM;
        rd_wen = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        imm    = imm_j;
        pc_sel = core_ctrl_pkg::JAL;
        wb_sel = core_ctrl_pkg::LINK;
        rd_wen = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        pc_sel = core_ctrl_pkg::JALR;  // imm_i is already the default
        wb_sel = core_ctrl_pkg::LINK;
        rd_wen = 1'b1;
      end
      rv_isa_pkg::BRANCH: begin
        imm    = imm_b;
        alu_op = core_ctrl_pkg::SUB;   // rs1 - rs2 drives the compare
        pc_sel = core_ctrl_pkg::BRANCH;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  wen,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  rv_isa_pkg::reg_addr_t raddr1,
  input  rv_isa_pkg::reg_addr_t raddr2,
  input  rv_isa_pkg::word_t     wdata,
  output rv_isa_pkg::word_t     rdata1,
  output rv_isa_pkg::word_t     rdata2
);

  rv_isa_pkg::word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read ports
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module alu (
  input  core_ctrl_pkg::alu_op_e alu_op,
  input  core_ctrl_pkg::a_sel_e  a_sel,
  input  core_ctrl_pkg::b_sel_e  b_sel,
  input  rv_isa_pkg::branch_f3_e branch_cond,
  input  rv_isa_pkg::word_t      rs1_data,
  input  rv_isa_pkg::word_t      rs2_data,
  input  rv_isa_pkg::word_t      imm,
  input  rv_isa_pkg::word_t      pc,
  output rv_isa_pkg::word_t      result,
  output logic                   cond_true
);

  rv_isa_pkg::word_t op_a;
  rv_isa_pkg::word_t op_b;
  rv_isa_pkg::word_t sum;
  rv_isa_pkg::word_t diff;
  logic              carry;    // no borrow, a >= b unsigned
  logic              overflow;
  logic              eq;
  logic              lt;
  logic              ltu;
  logic [4:0]        shamt;

  always_comb begin
    case (a_sel)
      core_ctrl_pkg::PC:   op_a = pc;
      core_ctrl_pkg::ZERO: op_a = '0;
      default:             op_a = rs1_data;
    endcase
  end

  assign op_b  = (b_sel == core_ctrl_pkg::IMM) ? imm : rs2_data;
  assign shamt = op_b[4:0];

  assign sum = op_a + op_b;

  // a + ~b + 1, shared by sub, slt and branches
  assign {carry, diff} = {1'b0, op_a} + {1'b0, ~op_b} + 1'b1;
  assign overflow = (op_a[`RV_XLEN-1] != op_b[`RV_XLEN-1]) &&
                    (diff[`RV_XLEN-1] != op_a[`RV_XLEN-1]);

  assign eq  = (diff == '0);
  assign lt  = diff[`RV_XLEN-1] ^ overflow;
  assign ltu = ~carry;

  always_comb begin
    case (alu_op)
      core_ctrl_pkg::SUB:  result = diff;
      core_ctrl_pkg::SLL:  result = op_a << shamt;
      core_ctrl_pkg::SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt};
      core_ctrl_pkg::SLTU: result = {{(`RV_XLEN-1){1'b0}}, ltu};
      core_ctrl_pkg::XOR:  result = op_a ^ op_b;
      core_ctrl_pkg::SRL:  result = op_a >> shamt;
      core_ctrl_pkg::SRA:  result = $signed(op_a) >>> shamt;
      core_ctrl_pkg::OR:   result = op_a | op_b;
      core_ctrl_pkg::AND:  result = op_a & op_b;
      default:             result = sum;
    endcase
  end

  always_comb begin
    case (branch_cond)
      rv_isa_pkg::BEQ:  cond_true = eq;
      rv_isa_pkg::BNE:  cond_true = !eq;
      rv_isa_pkg::BLT:  cond_true = lt;
      rv_isa_pkg::BGE:  cond_true = !lt;
      rv_isa_pkg::BLTU: cond_true = ltu;
      rv_isa_pkg::BGEU: cond_true = !ltu;
      default:          cond_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module pc_unit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  core_ctrl_pkg::pc_sel_e pc_sel,
  input  logic                   cond_true,
  input  rv_isa_pkg::word_t      imm,
  input  rv_isa_pkg::word_t      rs1_data,
  output rv_isa_pkg::word_t      pc,
  output rv_isa_pkg::word_t      link_pc
);

  rv_isa_pkg::word_t pc_q;
  rv_isa_pkg::word_t target_base;
  rv_isa_pkg::word_t target_sum;
  rv_isa_pkg::word_t target;
  rv_isa_pkg::word_t next_pc;

  assign link_pc = pc_q + rv_isa_pkg::word_t'(4); // sequential pc

  // jalr adds to rs1, everything else to pc
  assign target_base = (pc_sel == core_ctrl_pkg::JALR) ? rs1_data : pc_q;
  assign target_sum  = target_base + imm;
  assign target      = (pc_sel == core_ctrl_pkg::JALR) ?
                       {target_sum[`RV_XLEN-1:1], 1'b0} : target_sum;

  always_comb begin
    case (pc_sel)
      core_ctrl_pkg::JAL,
      core_ctrl_pkg::JALR:   next_pc = target;
      core_ctrl_pkg::BRANCH: next_pc = cond_true ? target : link_pc;
      default:               next_pc = link_pc;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= `RV_RESET_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign pc = pc_q;

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rv_isa_pkg::word_t     inst,
  output rv_isa_pkg::word_t     pc,
  output logic                  rd_wen,
  output rv_isa_pkg::reg_addr_t rd_addr,
  output rv_isa_pkg::word_t     rd_data
);

  rv_isa_pkg::reg_addr_t  rs1_addr;
  rv_isa_pkg::reg_addr_t  rs2_addr;
  rv_isa_pkg::word_t      imm;
  rv_isa_pkg::word_t      rs1_data;
  rv_isa_pkg::word_t      rs2_data;
  rv_isa_pkg::word_t      alu_result;
  rv_isa_pkg::word_t      link_pc;
  rv_isa_pkg::branch_f3_e branch_cond;
  core_ctrl_pkg::alu_op_e alu_op;
  core_ctrl_pkg::a_sel_e  a_sel;
  core_ctrl_pkg::b_sel_e  b_sel;
  core_ctrl_pkg::pc_sel_e pc_sel;
  core_ctrl_pkg::wb_sel_e wb_sel;
  logic                   cond_true;

  inst_decoder u_dec (
    .inst        (inst),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rd_addr     (rd_addr),
    .imm         (imm),
    .alu_op      (alu_op),
    .a_sel       (a_sel),
    .b_sel       (b_sel),
    .branch_cond (branch_cond),
    .pc_sel      (pc_sel),
    .wb_sel      (wb_sel),
    .rd_wen      (rd_wen)
  );

  // the commit port doubles as the register write port
  reg_file u_rf (
    .clk    (clk),
    .arst_n (arst_n),
    .wen    (rd_wen),
    .waddr  (rd_addr),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .wdata  (rd_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  alu u_alu (
    .alu_op      (alu_op),
    .a_sel       (a_sel),
    .b_sel       (b_sel),
    .branch_cond (branch_cond),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .result      (alu_result),
    .cond_true   (cond_true)
  );

  pc_unit u_pc (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc_sel    (pc_sel),
    .cond_true (cond_true),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .pc        (pc),
    .link_pc   (link_pc)
  );

  // jumps write the return address
  assign rd_data = (wb_sel == core_ctrl_pkg::LINK) ? link_pc : alu_result;

endmodule

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;

  localparam int N_ZERO  = 8;
  localparam int N_ALU   = 200;
  localparam int N_UPPER = 10;
  localparam int N_JUMP  = 8;
  // 33 seeding writes plus 2 + 6 x 3 branch and 2 x0 instructions
  localparam int N_TOTAL    = N_ZERO + 33 + N_ALU + 2 * N_UPPER + 20 + 2 * N_JUMP + 2;
  localparam int MAX_CYCLES = N_TOTAL * 3 / 2 + 20;

  logic        clk;
  logic        arst_n;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        rd_wen;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;

  logic [31:0] m_regs [32]; // shadow register file
  logic [31:0] m_pc;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  rv_core uut (
    .clk     (clk),
    .arst_n  (arst_n),
    .inst    (inst),
    .pc      (pc),
    .rd_wen  (rd_wen),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom % 32);
  endfunction

  // reference result of OP / OP_IMM by funct3
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                          input logic arith, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = sub ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (arith) begin
          r = $unsigned($signed(a) >>> b[4:0]);
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    logic t;
    case (f3)
      3'd0: t = (a == b);
      3'd1: t = (a != b);
      3'd4: t = ($signed(a) < $signed(b));
      3'd5: t = ($signed(a) >= $signed(b));
      3'd6: t = (a < b);
      3'd7: t = (a >= b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // runs from one falling edge to the next
  task automatic issue(input logic [31:0] instr);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        e_wen;
    logic [31:0] e_data;
    logic [31:0] e_next;
    opc    = instr[6:0];
    f3     = instr[14:12];
    rd     = instr[11:7];
    a      = m_regs[instr[19:15]];
    b      = m_regs[instr[24:20]];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u  = {instr[31:12], 12'h000};
    imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    e_wen  = 1'b0;
    e_data = '0;
    e_next = m_pc + 32'd4;
    case (opc)
      OPC_OP: begin
        e_wen  = 1'b1;
        e_data = alu_ref(f3, instr[30], instr[30], a, b);
      end
      OPC_OP_IMM: begin
        e_wen  = 1'b1;
        e_data = alu_ref(f3, 1'b0, instr[30], a, imm_i); // no subi
      end
      OPC_LUI: begin
        e_wen  = 1'b1;
        e_data = imm_u;
      end
      OPC_AUIPC: begin
        e_wen  = 1'b1;
        e_data = m_pc + imm_u;
      end
      OPC_JAL: begin
        e_wen  = 1'b1;
        e_data = m_pc + 32'd4;
        e_next = m_pc + imm_j;
      end
      OPC_JALR: begin
        e_wen  = 1'b1;
        e_data = m_pc + 32'd4;
        e_next = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        if (branch_ref(f3, a, b)) begin
          e_next = m_pc + imm_b;
        end
      end
      default: ; // unknown opcode retires nothing
    endcase

    inst = instr;
    #2;
    check("pc", pc, m_pc);
    check("rd_wen", 32'(rd_wen), 32'(e_wen));
    if (e_wen) begin
      check("rd_addr", 32'(rd_addr), 32'(rd));
      check("rd_data", rd_data, e_data);
    end
    @(posedge clk);
    if (e_wen && rd != 5'd0) begin
      m_regs[rd] = e_data;
    end
    m_pc = e_next;
    @(negedge clk);
  endtask

  task automatic seed_regs();
    logic [11:0] imm;
    for (int i = 1; i < 32; i++) begin
      case ($urandom % 4)
        0: imm = 12'h800;       // -2048
        1: imm = 12'h7ff;
        2: imm = 12'hfff;       // -1
        default: imm = 12'($urandom);
      endcase
      issue(enc_i(imm, 5'd0, 3'd0, 5'(i), OPC_OP_IMM));
    end
    issue(enc_u(20'h80000, 5'd1, OPC_LUI));              // most negative word
    issue(enc_i(12'hfff, 5'd1, 3'd0, 5'd2, OPC_OP_IMM)); // most positive word
  endtask

  task automatic run_alu_random();
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    repeat (N_ALU) begin
      f3  = 3'($urandom % 8);
      alt = 1'($urandom % 2);
      if ($urandom % 2 == 0) begin
        issue(enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                    rand_reg(), rand_reg(), f3, rand_reg()));
      end else begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {(alt && f3 == 3'd5) ? 7'h20 : 7'h00, 5'($urandom % 32)}; // shamt
        end else begin
          imm = 12'($urandom);
        end
        issue(enc_i(imm, rand_reg(), f3, rand_reg(), OPC_OP_IMM));
      end
    end
  endtask

  task automatic run_upper();
    repeat (N_UPPER) begin
      issue(enc_u(20'($urandom), rand_reg(), OPC_LUI));
      issue(enc_u(20'($urandom), rand_reg(), OPC_AUIPC));
    end
  endtask

  task automatic run_branches();
    logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    issue(enc_i(12'hfff, 5'd0, 3'd0, 5'd10, OPC_OP_IMM)); // x10 = -1
    issue(enc_i(12'h001, 5'd0, 3'd0, 5'd11, OPC_OP_IMM)); // x11 = 1
    foreach (conds[c]) begin
      issue(enc_b({12'($urandom), 1'b0}, 5'd10, 5'd10, conds[c])); // equal
      issue(enc_b({12'($urandom), 1'b0}, 5'd11, 5'd10, conds[c])); // signed less
      issue(enc_b({12'($urandom), 1'b0}, 5'd10, 5'd11, conds[c])); // unsigned less
    end
  endtask

  task automatic run_jumps();
    repeat (N_JUMP) begin
      issue(enc_j({20'($urandom), 1'b0}, rand_reg()));
      issue(enc_i(12'($urandom), rand_reg(), 3'd0, rand_reg(), OPC_JALR)); // odd sums too
    end
  endtask

  task automatic run_x0();
    issue(enc_i(12'h005, 5'd11, 3'd0, 5'd0, OPC_OP_IMM)); // port shows the write
    issue(enc_r(7'h00, 5'd0, 5'd11, 3'd0, 5'd12));        // x12 = x11 + x0
  endtask

  initial begin
    void'($urandom(32'hfd85_8bd6));
    arst_n   = 1'b0;
    inst     = '0;
    m_pc     = 32'h8000_0000;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    repeat (N_ZERO) issue(32'h0000_0000); // all-zero word is no instruction
    seed_regs();
    run_alu_random();
    run_upper();
    run_branches();
    run_jumps();
    run_x0();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/rv_core.sv
tests/tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_rv_core -o sim_rv_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_rv_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "testbench reported failure"
exit 1
